/* source/decode_pkg.sv */
package decode_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [6:0]  excp_code_t;          // Zero means no exception

    localparam excp_code_t EXC_INE = 7'h0D;

    typedef enum logic [3:0] {
        UOP_NONE,
        UOP_ADD,
        UOP_SUB,
        UOP_ADDI,
        UOP_LU12I,
        UOP_LD,
        UOP_ST,
        UOP_SYSCALL,
        UOP_BREAK,
        UOP_CSRRD
    } uop_t;

    // 3R and trap formats, bits 31..15
    localparam logic [16:0] OPC_ADD_W   = 17'h00020;
    localparam logic [16:0] OPC_SUB_W   = 17'h00022;
    localparam logic [16:0] OPC_SYSCALL = 17'h00056;
    localparam logic [16:0] OPC_BREAK   = 17'h00054;

    // 2RI12 format, bits 31..22
    localparam logic [9:0]  OPC_ADDI_W  = 10'h00A;
    localparam logic [9:0]  OPC_LD_W    = 10'h0A2;
    localparam logic [9:0]  OPC_ST_W    = 10'h0A6;

    localparam logic [6:0]  OPC_LU12I_W = 7'h0A;  // Bits 31..25

    // CSR group, bits 31..24; rj == 0 selects csrrd
    localparam logic [7:0]  OPC_CSR     = 8'h04;

    localparam int unsigned IQ_DEPTH = 4;         // Pairs, power of two 2..16
    localparam int unsigned IQ_PTR_W = $clog2(IQ_DEPTH);

    typedef logic [IQ_PTR_W-1:0] iq_ptr_t;
    typedef logic [IQ_PTR_W:0]   iq_cnt_t;

    // Queue entry minus the micro-ops: pc, code, flags, then two lanes
    localparam int unsigned IQ_LANE_W  = $bits(word_t) + 3 * $bits(reg_idx_t) + 4;
    localparam int unsigned IQ_ENTRY_W = $bits(word_t) + $bits(excp_code_t) + 2
                                         + 2 * IQ_LANE_W;

    typedef logic [IQ_ENTRY_W-1:0] iq_entry_t;

endpackage

/* source/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder (
    input  decode_pkg::word_t    inst,
    output decode_pkg::uop_t     uop,
    output decode_pkg::word_t    imm,
    output decode_pkg::reg_idx_t rd,
    output decode_pkg::reg_idx_t rj,
    output decode_pkg::reg_idx_t rk,
    output logic                 is_alu,
    output logic                 is_syscall,
    output logic                 is_break,
    output logic                 is_priv,
    output logic                 invalid
);

    logic [16:0]       op17;
    logic [9:0]        op10;
    logic [7:0]        op8;
    logic [6:0]        op7;
    decode_pkg::word_t si12_ext;
    decode_pkg::word_t ui20_hi;

    assign op17 = inst[31:15];
    assign op10 = inst[31:22];
    assign op8  = inst[31:24];
    assign op7  = inst[31:25];

    assign si12_ext = {{20{inst[21]}}, inst[21:10]};
    assign ui20_hi  = {inst[24:5], 12'h000};

    // Fixed field positions; st.w uses rd as store data
    assign rd = inst[4:0];
    assign rj = inst[9:5];
    assign rk = inst[14:10];

    always_comb begin
        uop = decode_pkg::UOP_NONE;
        if (op17 == decode_pkg::OPC_ADD_W) begin
            uop = decode_pkg::UOP_ADD;
        end else if (op17 == decode_pkg::OPC_SUB_W) begin
            uop = decode_pkg::UOP_SUB;
        end else if (op17 == decode_pkg::OPC_SYSCALL) begin
            uop = decode_pkg::UOP_SYSCALL;
        end else if (op17 == decode_pkg::OPC_BREAK) begin
            uop = decode_pkg::UOP_BREAK;
        end else if (op10 == decode_pkg::OPC_ADDI_W) begin
            uop = decode_pkg::UOP_ADDI;
        end else if (op10 == decode_pkg::OPC_LD_W) begin
            uop = decode_pkg::UOP_LD;
        end else if (op10 == decode_pkg::OPC_ST_W) begin
            uop = decode_pkg::UOP_ST;
        end else if (op7 == decode_pkg::OPC_LU12I_W) begin
            uop = decode_pkg::UOP_LU12I;
        end else if (op8 == decode_pkg::OPC_CSR && inst[9:5] == 5'd0) begin
            uop = decode_pkg::UOP_CSRRD;  // csrwr/csrxchg fall through as invalid
        end
    end

    always_comb begin
        imm        = '0;
        is_alu     = 1'b0;
        is_syscall = 1'b0;
        is_break   = 1'b0;
        is_priv    = 1'b0;
        case (uop)
            decode_pkg::UOP_ADD,
            decode_pkg::UOP_SUB: begin
                is_alu = 1'b1;
            end
            decode_pkg::UOP_ADDI: begin
                is_alu = 1'b1;
                imm    = si12_ext;
            end
            decode_pkg::UOP_LU12I: begin
                is_alu = 1'b1;
                imm    = ui20_hi;
            end
            decode_pkg::UOP_LD,
            decode_pkg::UOP_ST: begin
                imm = si12_ext;  // Address offset
            end
            decode_pkg::UOP_SYSCALL: begin
                is_syscall = 1'b1;
            end
            decode_pkg::UOP_BREAK: begin
                is_break = 1'b1;
            end
            decode_pkg::UOP_CSRRD: begin
                is_priv = 1'b1;
            end
            default: begin
                imm = '0;
            end
        endcase
    end

    assign invalid = (uop == decode_pkg::UOP_NONE);

endmodule

/* source/id_reg.sv */
`timescale 1ns/1ps

module id_reg (
    input  logic                     aclk,
    input  logic                     rst,
    input  logic                     flush,
    input  logic                     fetch_valid,
    input  logic                     reg_allowin,
    output logic                     id_allowin,
    output logic                     reg_valid,

    input  decode_pkg::word_t        fetch_pc,
    input  logic [1:0]               fetch_excp_flag,
    input  decode_pkg::excp_code_t   fetch_exception,

    input  decode_pkg::uop_t         uop0, uop1,
    input  decode_pkg::word_t        imm0, imm1,
    input  decode_pkg::reg_idx_t     rd0, rd1,
    input  decode_pkg::reg_idx_t     rj0, rj1,
    input  decode_pkg::reg_idx_t     rk0, rk1,
    input  logic                     is_alu0, is_alu1,
    input  logic                     is_syscall0, is_syscall1,
    input  logic                     is_break0, is_break1,
    input  logic                     is_priv0, is_priv1,
    input  logic                     invalid0, invalid1,

    output decode_pkg::word_t        reg_pc,
    output logic [1:0]               reg_excp_flag,
    output decode_pkg::excp_code_t   reg_exception,
    output decode_pkg::uop_t         reg_uop0, reg_uop1,
    output decode_pkg::word_t        reg_imm0, reg_imm1,
    output decode_pkg::reg_idx_t     reg_rd0, reg_rd1,
    output decode_pkg::reg_idx_t     reg_rj0, reg_rj1,
    output decode_pkg::reg_idx_t     reg_rk0, reg_rk1,
    output logic                     reg_is_alu0, reg_is_alu1,
    output logic                     reg_is_syscall0, reg_is_syscall1,
    output logic                     reg_is_break0, reg_is_break1,
    output logic                     reg_is_priv0, reg_is_priv1
);

    logic                   accept;
    decode_pkg::excp_code_t merged_code;

    assign id_allowin = ~reg_valid | reg_allowin;  // Empty or draining
    assign accept     = fetch_valid & id_allowin;

    // Fetch fault outranks a decode fault
    assign merged_code = (fetch_exception != '0) ? fetch_exception :
                         (invalid0 | invalid1)   ? decode_pkg::EXC_INE : '0;

    always_ff @(posedge aclk) begin
        if (rst || flush) begin
            reg_valid <= 1'b0;
        end else if (accept) begin
            reg_valid <= 1'b1;
        end else if (reg_allowin) begin
            reg_valid <= 1'b0;  // Bubble
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            reg_pc          <= fetch_pc;
            reg_excp_flag   <= fetch_excp_flag | {invalid1, invalid0};
            reg_exception   <= merged_code;
            reg_uop0        <= uop0;
            reg_uop1        <= uop1;
            reg_imm0        <= imm0;
            reg_imm1        <= imm1;
            reg_rd0         <= rd0;
            reg_rd1         <= rd1;
            reg_rj0         <= rj0;
            reg_rj1         <= rj1;
            reg_rk0         <= rk0;
            reg_rk1         <= rk1;
            reg_is_alu0     <= is_alu0;
            reg_is_alu1     <= is_alu1;
            reg_is_syscall0 <= is_syscall0;
            reg_is_syscall1 <= is_syscall1;
            reg_is_break0   <= is_break0;
            reg_is_break1   <= is_break1;
            reg_is_priv0    <= is_priv0;
            reg_is_priv1    <= is_priv1;
        end
    end

    // A stalled pair stays put until the queue takes it
    a_hold_on_stall: assert property (@(posedge aclk) disable iff (rst)
        (reg_valid && !reg_allowin && !flush) |=> reg_valid);

endmodule

/* source/issue_queue.sv */
`timescale 1ns/1ps

module issue_queue (
    input  logic                     aclk,
    input  logic                     rst,
    input  logic                     flush,
    input  logic                     reg_valid,
    output logic                     reg_allowin,

    input  decode_pkg::word_t        reg_pc,
    input  logic [1:0]               reg_excp_flag,
    input  decode_pkg::excp_code_t   reg_exception,
    input  decode_pkg::uop_t         reg_uop0, reg_uop1,
    input  decode_pkg::word_t        reg_imm0, reg_imm1,
    input  decode_pkg::reg_idx_t     reg_rd0, reg_rd1,
    input  decode_pkg::reg_idx_t     reg_rj0, reg_rj1,
    input  decode_pkg::reg_idx_t     reg_rk0, reg_rk1,
    input  logic                     reg_is_alu0, reg_is_alu1,
    input  logic                     reg_is_syscall0, reg_is_syscall1,
    input  logic                     reg_is_break0, reg_is_break1,
    input  logic                     reg_is_priv0, reg_is_priv1,

    input  logic                     iss_ready,
    output logic                     iss_valid,
    output decode_pkg::word_t        iss_pc,
    output logic [1:0]               iss_excp_flag,
    output decode_pkg::excp_code_t   iss_exception,
    output decode_pkg::uop_t         iss_uop0, iss_uop1,
    output decode_pkg::word_t        iss_imm0, iss_imm1,
    output decode_pkg::reg_idx_t     iss_rd0, iss_rd1,
    output decode_pkg::reg_idx_t     iss_rj0, iss_rj1,
    output decode_pkg::reg_idx_t     iss_rk0, iss_rk1,
    output logic                     iss_is_alu0, iss_is_alu1,
    output logic                     iss_is_syscall0, iss_is_syscall1,
    output logic                     iss_is_break0, iss_is_break1,
    output logic                     iss_is_priv0, iss_is_priv1
);

    decode_pkg::iq_entry_t entry_mem [decode_pkg::IQ_DEPTH];
    decode_pkg::uop_t      uop0_mem  [decode_pkg::IQ_DEPTH];
    decode_pkg::uop_t      uop1_mem  [decode_pkg::IQ_DEPTH];
    decode_pkg::iq_ptr_t   wr_ptr;
    decode_pkg::iq_ptr_t   rd_ptr;
    decode_pkg::iq_cnt_t   count;
    decode_pkg::iq_entry_t wr_entry;
    logic                  full;
    logic                  push;
    logic                  pop;

    assign full        = (count == decode_pkg::iq_cnt_t'(decode_pkg::IQ_DEPTH));
    assign reg_allowin = ~full | iss_ready;  // Full slot frees on a pop
    assign push        = reg_valid & reg_allowin;
    assign iss_valid   = (count != '0);
    assign pop         = iss_valid & iss_ready;

    assign wr_entry = {reg_pc, reg_exception, reg_excp_flag,
                       reg_imm0, reg_rd0, reg_rj0, reg_rk0,
                       reg_is_alu0, reg_is_syscall0, reg_is_break0, reg_is_priv0,
                       reg_imm1, reg_rd1, reg_rj1, reg_rk1,
                       reg_is_alu1, reg_is_syscall1, reg_is_break1, reg_is_priv1};

    assign {iss_pc, iss_exception, iss_excp_flag,
            iss_imm0, iss_rd0, iss_rj0, iss_rk0,
            iss_is_alu0, iss_is_syscall0, iss_is_break0, iss_is_priv0,
            iss_imm1, iss_rd1, iss_rj1, iss_rk1,
            iss_is_alu1, iss_is_syscall1, iss_is_break1, iss_is_priv1} = entry_mem[rd_ptr];

    assign iss_uop0 = uop0_mem[rd_ptr];
    assign iss_uop1 = uop1_mem[rd_ptr];

    always_ff @(posedge aclk) begin
        if (push) begin
            entry_mem[wr_ptr] <= wr_entry;
            uop0_mem[wr_ptr]  <= reg_uop0;
            uop1_mem[wr_ptr]  <= reg_uop1;
        end
    end

    always_ff @(posedge aclk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;  // Wraps at IQ_DEPTH
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            count <= count + decode_pkg::iq_cnt_t'(push) - decode_pkg::iq_cnt_t'(pop);
        end
    end

    a_count_bound: assert property (@(posedge aclk) disable iff (rst)
        count <= decode_pkg::iq_cnt_t'(decode_pkg::IQ_DEPTH));

    // Pointers equal and not full means empty
    a_no_pop_empty: assert property (@(posedge aclk) disable iff (rst)
        pop |-> (rd_ptr != wr_ptr || full));

endmodule

/* source/decode_top.sv */
`timescale 1ns/1ps

module decode_top (
    input  logic                     aclk,
    input  logic                     rst,
    input  logic                     flush,

    input  logic                     fetch_valid,
    input  decode_pkg::word_t        fetch_inst0,
    input  decode_pkg::word_t        fetch_inst1,
    input  decode_pkg::word_t        fetch_pc,      // Lane 1 sits at pc + 4
    input  logic [1:0]               fetch_excp_flag,
    input  decode_pkg::excp_code_t   fetch_exception,
    output logic                     id_allowin,

    input  logic                     iss_ready,
    output logic                     iss_valid,
    output decode_pkg::word_t        iss_pc,
    output logic [1:0]               iss_excp_flag,
    output decode_pkg::excp_code_t   iss_exception,
    output decode_pkg::uop_t         iss_uop0, iss_uop1,
    output decode_pkg::word_t        iss_imm0, iss_imm1,
    output decode_pkg::reg_idx_t     iss_rd0, iss_rd1,
    output decode_pkg::reg_idx_t     iss_rj0, iss_rj1,
    output decode_pkg::reg_idx_t     iss_rk0, iss_rk1,
    output logic                     iss_is_alu0, iss_is_alu1,
    output logic                     iss_is_syscall0, iss_is_syscall1,
    output logic                     iss_is_break0, iss_is_break1,
    output logic                     iss_is_priv0, iss_is_priv1
);

    // Decoder outputs
    decode_pkg::uop_t       uop0, uop1;
    decode_pkg::word_t      imm0, imm1;
    decode_pkg::reg_idx_t   rd0, rd1, rj0, rj1, rk0, rk1;
    logic                   is_alu0, is_alu1, is_syscall0, is_syscall1;
    logic                   is_break0, is_break1, is_priv0, is_priv1;
    logic                   invalid0, invalid1;

    // Stage register to queue
    logic                   reg_valid;
    logic                   reg_allowin;
    decode_pkg::word_t      reg_pc;
    logic [1:0]             reg_excp_flag;
    decode_pkg::excp_code_t reg_exception;
    decode_pkg::uop_t       reg_uop0, reg_uop1;
    decode_pkg::word_t      reg_imm0, reg_imm1;
    decode_pkg::reg_idx_t   reg_rd0, reg_rd1, reg_rj0, reg_rj1, reg_rk0, reg_rk1;
    logic                   reg_is_alu0, reg_is_alu1, reg_is_syscall0, reg_is_syscall1;
    logic                   reg_is_break0, reg_is_break1, reg_is_priv0, reg_is_priv1;

    inst_decoder u_dec0 (
        .inst       (fetch_inst0),
        .uop        (uop0),
        .imm        (imm0),
        .rd         (rd0),
        .rj         (rj0),
        .rk         (rk0),
        .is_alu     (is_alu0),
        .is_syscall (is_syscall0),
        .is_break   (is_break0),
        .is_priv    (is_priv0),
        .invalid    (invalid0)
    );

    inst_decoder u_dec1 (
        .inst       (fetch_inst1),
        .uop        (uop1),
        .imm        (imm1),
        .rd         (rd1),
        .rj         (rj1),
        .rk         (rk1),
        .is_alu     (is_alu1),
        .is_syscall (is_syscall1),
        .is_break   (is_break1),
        .is_priv    (is_priv1),
        .invalid    (invalid1)
    );

    // Wire names match port names one to one
    id_reg u_id_reg (.*);

    issue_queue u_iq (.*);

endmodule

/* tests/tb_decode_top.sv */
`timescale 1ns/1ps

module tb_decode_top;

    localparam int NUM_ROWS   = 20;
    localparam int LIMIT      = 40 * NUM_ROWS + 200;   // Cycles
    localparam int STALL_CYCS = 12;
    localparam int DRAIN_CYCS = 100;

    logic                   aclk = 1'b0;
    logic                   rst;
    logic                   flush;
    logic                   fetch_valid;
    decode_pkg::word_t      fetch_inst0, fetch_inst1, fetch_pc;
    logic [1:0]             fetch_excp_flag;
    decode_pkg::excp_code_t fetch_exception;
    logic                   id_allowin;
    logic                   iss_ready;
    logic                   iss_valid;
    decode_pkg::word_t      iss_pc;
    logic [1:0]             iss_excp_flag;
    decode_pkg::excp_code_t iss_exception;
    decode_pkg::uop_t       iss_uop0, iss_uop1;
    decode_pkg::word_t      iss_imm0, iss_imm1;
    decode_pkg::reg_idx_t   iss_rd0, iss_rd1, iss_rj0, iss_rj1, iss_rk0, iss_rk1;
    logic                   iss_is_alu0, iss_is_alu1, iss_is_syscall0, iss_is_syscall1;
    logic                   iss_is_break0, iss_is_break1, iss_is_priv0, iss_is_priv1;

    logic [31:0] tab_inst0 [NUM_ROWS];
    logic [31:0] tab_inst1 [NUM_ROWS];
    logic [31:0] tab_pc    [NUM_ROWS];
    logic [1:0]  tab_flag  [NUM_ROWS];
    logic [6:0]  tab_code  [NUM_ROWS];

    int          sb [$];          // Row indices in flight, oldest first
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    logic [31:0] rng;

    decode_top UUT (.*);

    always #50 aclk = ~aclk;

    always @(posedge aclk) begin
        cycles = cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout: run still busy after %0d cycles", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Expected decode straight from the opcode map
    function automatic void ref_decode(input logic [31:0] inst, output logic [3:0] uop,
                                       output logic [31:0] imm, output logic [3:0] cls,
                                       output logic inv);
        uop = decode_pkg::UOP_NONE;
        imm = 32'h0;
        cls = 4'b0000;                        // {alu, syscall, break, priv}
        if (inst[31:15] == 17'h00020) begin
            uop = decode_pkg::UOP_ADD;
            cls = 4'b1000;
        end else if (inst[31:15] == 17'h00022) begin
            uop = decode_pkg::UOP_SUB;
            cls = 4'b1000;
        end else if (inst[31:15] == 17'h00056) begin
            uop = decode_pkg::UOP_SYSCALL;
            cls = 4'b0100;
        end else if (inst[31:15] == 17'h00054) begin
            uop = decode_pkg::UOP_BREAK;
            cls = 4'b0010;
        end else if (inst[31:22] == 10'h00A) begin
            uop = decode_pkg::UOP_ADDI;
            imm = {{20{inst[21]}}, inst[21:10]};
            cls = 4'b1000;
        end else if (inst[31:22] == 10'h0A2 || inst[31:22] == 10'h0A6) begin
            uop = (inst[24]) ? decode_pkg::UOP_ST : decode_pkg::UOP_LD;   // 0x0A6 vs 0x0A2
            imm = {{20{inst[21]}}, inst[21:10]};
        end else if (inst[31:25] == 7'h0A) begin
            uop = decode_pkg::UOP_LU12I;
            imm = {inst[24:5], 12'h000};
            cls = 4'b1000;
        end else if (inst[31:24] == 8'h04 && inst[9:5] == 5'd0) begin
            uop = decode_pkg::UOP_CSRRD;
            cls = 4'b0001;
        end
        inv = (uop == decode_pkg::UOP_NONE);
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("FAIL %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_lane(input string name, input logic [31:0] inst,
                              input logic [3:0] uop, input logic [31:0] imm,
                              input logic [4:0] rd, input logic [4:0] rj,
                              input logic [4:0] rk, input logic [3:0] cls);
        logic [3:0]  exp_uop;
        logic [31:0] exp_imm;
        logic [3:0]  exp_cls;
        logic        exp_inv;
        ref_decode(inst, exp_uop, exp_imm, exp_cls, exp_inv);
        check({name, " uop"}, uop, exp_uop);
        check({name, " imm"}, imm, exp_imm);
        check({name, " rd"}, rd, inst[4:0]);
        check({name, " rj"}, rj, inst[9:5]);
        check({name, " rk"}, rk, inst[14:10]);
        check({name, " class flags"}, cls, exp_cls);
    endtask

    task automatic check_pair(input int row);
        logic [3:0]  u;
        logic [31:0] i;
        logic [3:0]  c;
        logic        inv0, inv1;
        logic [6:0]  exp_code;
        string       tag;
        ref_decode(tab_inst0[row], u, i, c, inv0);
        ref_decode(tab_inst1[row], u, i, c, inv1);
        // Fetch code first, then INE
        exp_code = (tab_code[row] != 7'h0) ? tab_code[row] : (inv0 | inv1) ? 7'h0D : 7'h00;
        tag = $sformatf("row %0d", row);
        check({tag, " pc"}, iss_pc, tab_pc[row]);
        check({tag, " exception flags"}, iss_excp_flag, tab_flag[row] | {inv1, inv0});
        check({tag, " exception code"}, iss_exception, exp_code);
        check_lane({tag, " lane0"}, tab_inst0[row], iss_uop0, iss_imm0, iss_rd0, iss_rj0,
                   iss_rk0, {iss_is_alu0, iss_is_syscall0, iss_is_break0, iss_is_priv0});
        check_lane({tag, " lane1"}, tab_inst1[row], iss_uop1, iss_imm1, iss_rd1, iss_rj1,
                   iss_rk1, {iss_is_alu1, iss_is_syscall1, iss_is_break1, iss_is_priv1});
    endtask

    // Inputs are steady from 1 ns after the edge, so negedge sees the edge's handshake
    always @(negedge aclk) begin
        if (!rst && iss_valid && iss_ready) begin
            if (sb.size() == 0) begin
                errors = errors + 1;
                $display("Issue side took a pair at %0d ns when none was expected", $time);
            end else begin
                check_pair(sb.pop_front());
            end
        end
    end

    task automatic set_row(input int r, input logic [31:0] i0, input logic [31:0] i1,
                           input logic [1:0] flag, input logic [6:0] code);
        tab_inst0[r] = i0;
        tab_inst1[r] = i1;
        tab_pc[r]    = 32'h1C00_0000 + 32'(r * 8);
        tab_flag[r]  = flag;
        tab_code[r]  = code;
    endtask

    task automatic build_table();
        set_row(0,  {17'h00020, 5'd3, 5'd2, 5'd1}, {17'h00022, 5'd6, 5'd5, 5'd4}, 2'b00, 7'h00);
        set_row(1,  {10'h00A, 12'h123, 5'd8, 5'd7}, {10'h00A, 12'hFFF, 5'd10, 5'd9}, 2'b00, 7'h00);
        set_row(2,  {7'h0A, 20'h12345, 5'd11}, {7'h0A, 20'h80001, 5'd12}, 2'b00, 7'h00);
        set_row(3,  {10'h0A2, 12'h7FF, 5'd14, 5'd13}, {10'h0A6, 12'h800, 5'd16, 5'd15},
                2'b00, 7'h00);
        set_row(4,  {17'h00056, 15'h0011}, {17'h00054, 15'h0022}, 2'b00, 7'h00);
        set_row(5,  {8'h04, 14'h0005, 5'd0, 5'd17}, {17'h00020, 5'd29, 5'd30, 5'd31},
                2'b00, 7'h00);
        set_row(6,  32'hFFFF_FFFF, {17'h00020, 5'd1, 5'd1, 5'd1}, 2'b00, 7'h00);
        set_row(7,  {17'h00022, 5'd2, 5'd3, 5'd4}, 32'h0000_0000, 2'b00, 7'h00);
        set_row(8,  {8'h04, 14'h0006, 5'd1, 5'd18}, {17'h00022, 5'd7, 5'd8, 5'd9}, 2'b00, 7'h00);
        set_row(9,  {17'h00020, 5'd1, 5'd2, 5'd3}, {17'h00020, 5'd4, 5'd5, 5'd6}, 2'b01, 7'h08);
        set_row(10, 32'hFFFF_FFFF, 32'h0000_0000, 2'b10, 7'h08);   // Fetch code beats INE
        set_row(11, 32'h0000_0000, {10'h0A2, 12'h004, 5'd1, 5'd2}, 2'b00, 7'h00);
        set_row(12, {10'h0A2, 12'h010, 5'd2, 5'd3}, {10'h0A6, 12'hFF0, 5'd2, 5'd4},
                2'b11, 7'h03);
        set_row(13, {17'h00021, 5'd1, 5'd2, 5'd3}, {10'h00A, 12'h001, 5'd0, 5'd1}, 2'b00, 7'h00);
        set_row(14, {10'h0A4, 12'h020, 5'd3, 5'd4}, {7'h0A, 20'hFFFFF, 5'd31}, 2'b01, 7'h00);
        set_row(15, {17'h00054, 15'h0000}, {17'h00056, 15'h7FFF}, 2'b10, 7'h08);
        set_row(16, {8'h04, 14'h3FFF, 5'd0, 5'd5}, {17'h00022, 5'd31, 5'd31, 5'd31},
                2'b00, 7'h00);
        set_row(17, {10'h0A6, 12'h000, 5'd31, 5'd0}, {10'h0A2, 12'hFFF, 5'd0, 5'd31},
                2'b00, 7'h00);
        set_row(18, {7'h0A, 20'h00000, 5'd0}, {8'h04, 14'h0001, 5'd2, 5'd3}, 2'b00, 7'h00);
        set_row(19, {17'h00020, 5'd0, 5'd0, 5'd0}, {10'h00A, 12'h800, 5'd31, 5'd31},
                2'b00, 7'h01);
    endtask

    // One clock of fetch offer; starts and ends 1 ns after a rising edge
    task automatic offer_cycle(input int row, input logic valid, output logic took);
        fetch_valid     = valid;
        fetch_inst0     = tab_inst0[row];
        fetch_inst1     = tab_inst1[row];
        fetch_pc        = tab_pc[row];
        fetch_excp_flag = tab_flag[row];
        fetch_exception = tab_code[row];
        @(negedge aclk);
        took = valid && id_allowin;
        if (took) sb.push_back(row);
        @(posedge aclk);
        #1;
    endtask

    task automatic run_rows(input logic random_mode);
        int   row;
        logic valid;
        logic took;
        row = 0;
        while (row < NUM_ROWS) begin
            valid = 1'b1;
            if (random_mode) begin
                rng       = xorshift32(rng);
                valid     = rng[3] | rng[7];
                iss_ready = rng[1];
            end
            offer_cycle(row, valid, took);
            if (took) row = row + 1;
        end
        fetch_valid = 1'b0;
    endtask

    task automatic drain(input logic random_mode);
        int waited;
        waited = 0;
        while (sb.size() != 0 && waited < DRAIN_CYCS) begin
            if (random_mode) begin
                rng       = xorshift32(rng);
                iss_ready = rng[1];
            end
            @(posedge aclk);
            #1;
            waited = waited + 1;
        end
        if (sb.size() != 0) begin
            errors = errors + 1;
            $display("%0d expected pairs never issued", sb.size());
            sb.delete();
        end
    endtask

    task automatic flush_pipeline();
        fetch_valid = 1'b0;
        flush       = 1'b1;
        @(negedge aclk);
        sb.delete();                          // Pairs in flight are discarded
        @(posedge aclk);
        #1;
        flush = 1'b0;
    endtask

    initial begin
        logic took;
        int   row;
        int   accepts;
        rst             = 1'b1;
        flush           = 1'b0;
        fetch_valid     = 1'b0;
        fetch_inst0     = '0;
        fetch_inst1     = '0;
        fetch_pc        = '0;
        fetch_excp_flag = '0;
        fetch_exception = '0;
        iss_ready       = 1'b0;
        rng             = 32'd9;
        build_table();
        repeat (4) @(posedge aclk);
        #1;
        rst = 1'b0;

        check("iss_valid after reset", iss_valid, 1'b0);
        check("id_allowin after reset", id_allowin, 1'b1);

        // Whole table with the issue side always ready
        iss_ready = 1'b1;
        run_rows(1'b0);
        drain(1'b0);
        check("iss_valid after drain", iss_valid, 1'b0);

        // Back-pressure fills queue and id_reg
        iss_ready = 1'b0;
        row       = 0;
        accepts   = 0;
        repeat (STALL_CYCS) begin
            offer_cycle(row, 1'b1, took);
            if (took) begin
                row     = row + 1;
                accepts = accepts + 1;
            end
        end
        check("pairs accepted under stall", accepts, decode_pkg::IQ_DEPTH + 1);
        check("id_allowin under stall", id_allowin, 1'b0);
        fetch_valid = 1'b0;
        iss_ready   = 1'b1;
        drain(1'b0);

        // Flush with a full queue and a loaded id_reg
        iss_ready = 1'b0;
        row       = 10;
        repeat (STALL_CYCS) begin
            offer_cycle(row, 1'b1, took);
            if (took) row = row + 1;
        end
        check("id_allowin before flush", id_allowin, 1'b0);
        flush_pipeline();
        repeat (3) begin
            check("iss_valid after flush", iss_valid, 1'b0);
            @(posedge aclk);
            #1;
        end
        check("id_allowin after flush", id_allowin, 1'b1);

        // Random ready and toggling fetch_valid
        run_rows(1'b1);
        drain(1'b1);

        $display("Checks: %0d  errors: %0d  cycles: %0d", checks, errors, cycles);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* filelist.f */
source/decode_pkg.sv
source/inst_decoder.sv
source/id_reg.sv
source/issue_queue.sv
source/decode_top.sv
tests/tb_decode_top.sv

/* Makefile */
TOP := tb_decode_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f filelist.f --top-module $(TOP)

# Pass only when the pass line shows up in the simulation output
run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "=== PASS ==="

lint:
	verilator --lint-only -Wall --timing -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir
